// File: Makefile
SIM       = verilator
SIMFLAGS  = --binary --timing -Wno-fatal
TOP       = tb_axi_master
FILELIST  = build.f
BUILD_DIR = obj_dir

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: axi_master_top.sv
`timescale 1ns/1ps

module axi_master_top
  import axi_pkg::*;
  import mem_req_pkg::*;
(
  input  logic       clock,
  input  logic       reset_i,
  input  logic       user_valid_i,
  input  mem_req_t   user_req_i,
  output logic       user_ready_o,
  output line_t      user_rdata_o,
  output axi_resp_t  user_resp_o,
  input  logic       io_master_awready_i,
  output logic       io_master_awvalid_o,
  output axi_addr_t  io_master_awaddr_o,
  output axi_id_t    io_master_awid_o,
  output axi_len_t   io_master_awlen_o,
  output axi_size_t  io_master_awsize_o,
  output axi_burst_t io_master_awburst_o,
  input  logic       io_master_wready_i,
  output logic       io_master_wvalid_o,
  output axi_data_t  io_master_wdata_o,
  output axi_strb_t  io_master_wstrb_o,
  output logic       io_master_wlast_o,
  output logic       io_master_bready_o,
  input  logic       io_master_bvalid_i,
  input  axi_resp_t  io_master_bresp_i,
  input  logic       io_master_arready_i,
  output logic       io_master_arvalid_o,
  output axi_addr_t  io_master_araddr_o,
  output axi_id_t    io_master_arid_o,
  output axi_len_t   io_master_arlen_o,
  output axi_size_t  io_master_arsize_o,
  output axi_burst_t io_master_arburst_o,
  output logic       io_master_rready_o,
  input  logic       io_master_rvalid_i,
  input  axi_resp_t  io_master_rresp_i,
  input  axi_data_t  io_master_rdata_i,
  input  logic       io_master_rlast_i
);

  logic      wr_start;
  logic      rd_start;
  logic      wr_done;
  logic      rd_done;
  axi_resp_t wr_resp;
  axi_resp_t rd_resp;
  axi_ax_t   ax;
  line_t     wline;
  line_t     rd_line;
  axi_ax_t   aw_bus;
  axi_ax_t   ar_bus;
  axi_w_t    w_bus;
  axi_r_t    r_bus;

  axi_req_ctrl u_ctrl (
    .clock        (clock),
    .reset_i      (reset_i),
    .user_valid_i (user_valid_i),
    .user_req_i   (user_req_i),
    .user_ready_o (user_ready_o),
    .user_rdata_o (user_rdata_o),
    .user_resp_o  (user_resp_o),
    .wr_start_o   (wr_start),
    .rd_start_o   (rd_start),
    .ax_o         (ax),
    .wline_o      (wline),
    .wr_done_i    (wr_done),
    .rd_done_i    (rd_done),
    .wr_resp_i    (wr_resp),
    .rd_resp_i    (rd_resp),
    .rd_line_i    (rd_line)
  );

  axi_wr_engine u_wr (
    .clock      (clock),
    .reset_i    (reset_i),
    .start_i    (wr_start),
    .ax_i       (ax),
    .wline_i    (wline),
    .done_o     (wr_done),
    .resp_o     (wr_resp),
    .aw_valid_o (io_master_awvalid_o),
    .aw_ready_i (io_master_awready_i),
    .aw_o       (aw_bus),
    .w_valid_o  (io_master_wvalid_o),
    .w_ready_i  (io_master_wready_i),
    .w_o        (w_bus),
    .b_valid_i  (io_master_bvalid_i),
    .b_ready_o  (io_master_bready_o),
    .b_resp_i   (io_master_bresp_i)
  );

  axi_rd_engine u_rd (
    .clock      (clock),
    .reset_i    (reset_i),
    .start_i    (rd_start),
    .ax_i       (ax),
    .done_o     (rd_done),
    .resp_o     (rd_resp),
    .line_o     (rd_line),
    .ar_valid_o (io_master_arvalid_o),
    .ar_ready_i (io_master_arready_i),
    .ar_o       (ar_bus),
    .r_valid_i  (io_master_rvalid_i),
    .r_ready_o  (io_master_rready_o),
    .r_i        (r_bus)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Flat AXI ports.
  // ~~~~~~~~~~~~~~~~~~~~
  assign io_master_awaddr_o  = aw_bus.addr;
  assign io_master_awid_o    = aw_bus.id;
  assign io_master_awlen_o   = aw_bus.len;
  assign io_master_awsize_o  = aw_bus.size;
  assign io_master_awburst_o = aw_bus.burst;

  assign io_master_wdata_o = w_bus.data;
  assign io_master_wstrb_o = w_bus.strb;
  assign io_master_wlast_o = w_bus.last;

  assign io_master_araddr_o  = ar_bus.addr;
  assign io_master_arid_o    = ar_bus.id;
  assign io_master_arlen_o   = ar_bus.len;
  assign io_master_arsize_o  = ar_bus.size;
  assign io_master_arburst_o = ar_bus.burst;

  // Single ID in flight, so R carries no ID.
  assign r_bus.data = io_master_rdata_i;
  assign r_bus.resp = io_master_rresp_i;
  assign r_bus.last = io_master_rlast_i;
  assign r_bus.id   = AXI_ID;

endmodule

// File: axi_pkg.sv
package axi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Field widths.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned AXI_ADDR_W  = 32;
  localparam int unsigned AXI_DATA_W  = 64;
  localparam int unsigned AXI_STRB_W  = AXI_DATA_W / 8;
  localparam int unsigned AXI_ID_W    = 4;
  localparam int unsigned AXI_LEN_W   = 8;
  localparam int unsigned AXI_SIZE_W  = 3;
  localparam int unsigned AXI_BURST_W = 2;
  localparam int unsigned AXI_RESP_W  = 2;

  typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;
  typedef logic [AXI_DATA_W-1:0]  axi_data_t;
  typedef logic [AXI_STRB_W-1:0]  axi_strb_t;
  typedef logic [AXI_ID_W-1:0]    axi_id_t;
  typedef logic [AXI_LEN_W-1:0]   axi_len_t;
  typedef logic [AXI_SIZE_W-1:0]  axi_size_t;
  typedef logic [AXI_BURST_W-1:0] axi_burst_t;
  typedef logic [AXI_RESP_W-1:0]  axi_resp_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Encodings.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam axi_id_t    AXI_ID          = '0;
  localparam axi_burst_t AXI_BURST_INCR  = 2'b01;
  localparam axi_resp_t  AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t  AXI_RESP_SLVERR = 2'b10;
  localparam axi_resp_t  AXI_RESP_DECERR = 2'b11;

  // Address phase, same layout for AW and AR.
  typedef struct packed {
    axi_addr_t  addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
    axi_id_t   id;
  } axi_r_t;

endpackage

// File: axi_rd_engine.sv
`timescale 1ns/1ps

module axi_rd_engine
  import axi_pkg::*;
  import mem_req_pkg::*;
(
  input  logic      clock,
  input  logic      reset_i,
  input  logic      start_i,
  input  axi_ax_t   ax_i,
  output logic      done_o,
  output axi_resp_t resp_o,
  output line_t     line_o,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  output axi_ax_t   ar_o,
  input  logic      r_valid_i,
  output logic      r_ready_o,
  input  axi_r_t    r_i
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_e;

  state_e    state_q;
  axi_len_t  beat_q;
  axi_ax_t   ax_q;
  logic      done_q;
  axi_resp_t resp_q;
  line_t     line_q;
  beat_idx_t beat_idx;
  logic      r_fire;

  assign r_fire   = r_valid_i && (state_q == DATA);
  assign beat_idx = beat_q[$bits(beat_idx_t)-1:0];

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE:    if (start_i) state_q <= ADDR;
        ADDR: begin
          if (ar_ready_i) begin
            beat_q  <= '0;
            state_q <= DATA;
          end
        end
        DATA: begin
          if (r_valid_i) begin
            beat_q <= beat_q + 1'b1;
            if (r_i.last) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Line assembly.
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (state_q == IDLE && start_i) begin
      ax_q   <= ax_i;
      line_q <= '0;
      resp_q <= AXI_RESP_OKAY;
    end
    if (r_fire) begin
      // Beats past the line end are dropped.
      if (beat_q < LINE_BEATS) line_q[BEAT_W*beat_idx +: BEAT_W] <= r_i.data;
      // Worst code wins.
      if (r_i.resp > resp_q) resp_q <= r_i.resp;
    end
  end

  assign ar_o       = ax_q;
  assign ar_valid_o = (state_q == ADDR);
  assign r_ready_o  = (state_q == DATA);
  assign done_o     = done_q;
  assign resp_o     = resp_q;
  assign line_o     = line_q;

endmodule

// File: axi_req_ctrl.sv
`timescale 1ns/1ps

module axi_req_ctrl
  import axi_pkg::*;
  import mem_req_pkg::*;
(
  input  logic      clock,
  input  logic      reset_i,
  input  logic      user_valid_i,
  input  mem_req_t  user_req_i,
  output logic      user_ready_o,
  output line_t     user_rdata_o,
  output axi_resp_t user_resp_o,
  output logic      wr_start_o,
  output logic      rd_start_o,
  output axi_ax_t   ax_o,
  output line_t     wline_o,
  input  logic      wr_done_i,
  input  logic      rd_done_i,
  input  axi_resp_t wr_resp_i,
  input  axi_resp_t rd_resp_i,
  input  line_t     rd_line_i
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    REPLY
  } state_e;

  state_e    state_q;
  mem_req_t  req_q;
  line_t     rdata_q;
  axi_resp_t resp_q;
  logic      is_write;
  logic      eng_done;

  assign is_write = (req_q.op == REQ_WRITE);
  assign eng_done = is_write ? wr_done_i : rd_done_i;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (user_valid_i) state_q <= ISSUE;
        ISSUE:   state_q <= WAIT;
        WAIT:    if (eng_done) state_q <= REPLY;
        REPLY:   state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request is held until the reply goes out.
  always_ff @(posedge clock) begin
    if (state_q == IDLE && user_valid_i) begin
      req_q <= user_req_i;
    end
    if (state_q == WAIT && eng_done) begin
      resp_q  <= is_write ? wr_resp_i : rd_resp_i;
      rdata_q <= is_write ? '0 : rd_line_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Engine dispatch.
  // ~~~~~~~~~~~~~~~~~~~~
  assign wr_start_o = (state_q == ISSUE) && is_write;
  assign rd_start_o = (state_q == ISSUE) && !is_write;

  // Upper address bits dropped.
  assign ax_o.addr  = req_q.addr[AXI_ADDR_W-1:0];
  assign ax_o.id    = AXI_ID;
  assign ax_o.len   = axi_len_t'(req_q.blks);
  assign ax_o.size  = axi_size_t'(req_q.size);
  assign ax_o.burst = AXI_BURST_INCR;
  assign wline_o    = req_q.wline;

  assign user_ready_o = (state_q == REPLY);
  assign user_rdata_o = rdata_q;
  assign user_resp_o  = resp_q;

endmodule

// File: axi_wr_engine.sv
`timescale 1ns/1ps

module axi_wr_engine
  import axi_pkg::*;
  import mem_req_pkg::*;
(
  input  logic      clock,
  input  logic      reset_i,
  input  logic      start_i,
  input  axi_ax_t   ax_i,
  input  line_t     wline_i,
  output logic      done_o,
  output axi_resp_t resp_o,
  output logic      aw_valid_o,
  input  logic      aw_ready_i,
  output axi_ax_t   aw_o,
  output logic      w_valid_o,
  input  logic      w_ready_i,
  output axi_w_t    w_o,
  input  logic      b_valid_i,
  output logic      b_ready_o,
  input  axi_resp_t b_resp_i
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA,
    RESP
  } state_e;

  state_e    state_q;
  axi_len_t  beat_q;
  axi_ax_t   ax_q;
  logic      done_q;
  axi_resp_t resp_q;
  beat_idx_t beat_idx;
  axi_data_t slice;
  axi_strb_t size_mask;
  logic [2:0] lane_off;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) state_q <= ADDR;
        end
        ADDR: begin
          if (aw_ready_i) begin
            beat_q  <= '0;
            state_q <= DATA;
          end
        end
        DATA: begin
          if (w_ready_i) begin
            beat_q <= beat_q + 1'b1;
            if (w_o.last) state_q <= RESP;
          end
        end
        RESP: begin
          if (b_valid_i) begin
            done_q  <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == IDLE && start_i) ax_q <= ax_i;
    if (state_q == RESP && b_valid_i) resp_q <= b_resp_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Beat data and strobes.
  // ~~~~~~~~~~~~~~~~~~~~
  assign beat_idx = beat_q[$bits(beat_idx_t)-1:0];
  assign slice    = wline_i[BEAT_W*beat_idx +: BEAT_W];
  // Full-width beats are always aligned.
  assign lane_off = (ax_q.size == 3'd3) ? 3'd0 : ax_q.addr[2:0];

  always_comb begin
    case (ax_q.size)
      3'd0:    size_mask = 8'h01;
      3'd1:    size_mask = 8'h03;
      3'd2:    size_mask = 8'h0F;
      default: size_mask = 8'hFF;
    endcase
  end

  assign w_o.data = slice << {lane_off, 3'b000};
  assign w_o.strb = size_mask << lane_off;
  assign w_o.last = (beat_q == ax_q.len);

  assign aw_o       = ax_q;
  assign aw_valid_o = (state_q == ADDR);
  assign w_valid_o  = (state_q == DATA);
  assign b_ready_o  = (state_q == RESP);
  assign done_o     = done_q;
  assign resp_o     = resp_q;

endmodule

// File: build.f
axi_pkg.sv
mem_req_pkg.sv
axi_req_ctrl.sv
axi_wr_engine.sv
axi_rd_engine.sv
axi_master_top.sv
tb_axi_slave_mem.sv
tb_axi_master.sv

// File: mem_req_pkg.sv
package mem_req_pkg;

  // 64-bit beats per cache line.
  localparam int unsigned LINE_BEATS = 8;
  localparam int unsigned BEAT_W     = 64;
  localparam int unsigned LINE_W     = LINE_BEATS * BEAT_W;

  typedef logic [63:0]       req_addr_t;
  typedef logic [LINE_W-1:0] line_t;

  // log2 of bytes per beat, 0 to 3.
  typedef logic [1:0] req_size_t;

  // Beat count minus one.
  typedef logic [7:0] req_blks_t;

  // Index of one beat slice inside a line.
  typedef logic [$clog2(LINE_BEATS)-1:0] beat_idx_t;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // User request.
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    req_op_e   op;
    req_addr_t addr;
    req_size_t size;
    req_blks_t blks;
    line_t     wline;
  } mem_req_t;

endpackage

// File: tb_axi_master.sv
`timescale 1ns/1ps

module tb_axi_master
  import axi_pkg::*;
  import mem_req_pkg::*;
();

  localparam axi_addr_t NORM_BASE = 32'h8000_0000;
  localparam axi_addr_t ERR_BASE  = 32'h9000_0000;
  localparam int        LINES     = 16;
  localparam int        TIMEOUT   = 2000;

  logic       clock;
  logic       reset_i;
  logic       user_valid_i;
  mem_req_t   user_req_i;
  logic       user_ready_o;
  line_t      user_rdata_o;
  axi_resp_t  user_resp_o;

  logic       aw_valid;
  logic       aw_ready;
  axi_addr_t  aw_addr;
  axi_id_t    aw_id;
  axi_len_t   aw_len;
  axi_size_t  aw_size;
  axi_burst_t aw_burst;
  logic       w_valid;
  logic       w_ready;
  axi_data_t  w_data;
  axi_strb_t  w_strb;
  logic       w_last;
  logic       b_valid;
  logic       b_ready;
  axi_resp_t  b_resp;
  logic       ar_valid;
  logic       ar_ready;
  axi_addr_t  ar_addr;
  axi_id_t    ar_id;
  axi_len_t   ar_len;
  axi_size_t  ar_size;
  axi_burst_t ar_burst;
  logic       r_valid;
  logic       r_ready;
  axi_ax_t    aw_bus;
  axi_ax_t    ar_bus;
  axi_w_t     w_bus;
  axi_r_t     r_bus;
  axi_ax_t    seen_ax;
  logic       proto_err;

  logic [7:0] model_mem [axi_addr_t];
  integer     seed = 23;

  axi_master_top UUT (
    .clock               (clock),
    .reset_i             (reset_i),
    .user_valid_i        (user_valid_i),
    .user_req_i          (user_req_i),
    .user_ready_o        (user_ready_o),
    .user_rdata_o        (user_rdata_o),
    .user_resp_o         (user_resp_o),
    .io_master_awready_i (aw_ready),
    .io_master_awvalid_o (aw_valid),
    .io_master_awaddr_o  (aw_addr),
    .io_master_awid_o    (aw_id),
    .io_master_awlen_o   (aw_len),
    .io_master_awsize_o  (aw_size),
    .io_master_awburst_o (aw_burst),
    .io_master_wready_i  (w_ready),
    .io_master_wvalid_o  (w_valid),
    .io_master_wdata_o   (w_data),
    .io_master_wstrb_o   (w_strb),
    .io_master_wlast_o   (w_last),
    .io_master_bready_o  (b_ready),
    .io_master_bvalid_i  (b_valid),
    .io_master_bresp_i   (b_resp),
    .io_master_arready_i (ar_ready),
    .io_master_arvalid_o (ar_valid),
    .io_master_araddr_o  (ar_addr),
    .io_master_arid_o    (ar_id),
    .io_master_arlen_o   (ar_len),
    .io_master_arsize_o  (ar_size),
    .io_master_arburst_o (ar_burst),
    .io_master_rready_o  (r_ready),
    .io_master_rvalid_i  (r_valid),
    .io_master_rresp_i   (r_bus.resp),
    .io_master_rdata_i   (r_bus.data),
    .io_master_rlast_i   (r_bus.last)
  );

  assign aw_bus = {aw_addr, aw_id, aw_len, aw_size, aw_burst};
  assign ar_bus = {ar_addr, ar_id, ar_len, ar_size, ar_burst};
  assign w_bus  = {w_data, w_strb, w_last};

  tb_axi_slave_mem #(.ERR_BASE(ERR_BASE)) u_slave (
    .clock       (clock),
    .reset_i     (reset_i),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .aw_i        (aw_bus),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .w_i         (w_bus),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .b_resp_o    (b_resp),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_i        (ar_bus),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .r_o         (r_bus),
    .seen_ax_o   (seen_ax),
    .proto_err_o (proto_err)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [511:0] exp,
                               input logic [511:0] act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  task automatic check_outputs_idle(input string name);
    compare_value({name, " user_ready_o"}, 0, user_ready_o);
    compare_value({name, " awvalid"}, 0, aw_valid);
    compare_value({name, " wvalid"}, 0, w_valid);
    compare_value({name, " arvalid"}, 0, ar_valid);
    compare_value({name, " bready"}, 0, b_ready);
    compare_value({name, " rready"}, 0, r_ready);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Memory model.
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [7:0] model_byte(input axi_addr_t a);
    if (model_mem.exists(a)) return model_mem[a];
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  function automatic axi_resp_t expected_resp(input axi_addr_t a);
    return (a >= ERR_BASE) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
  endfunction

  // Beat k holds the aligned bus word k, unused slices stay zero.
  function automatic line_t expected_read(input axi_addr_t a, input req_blks_t blks);
    line_t     l;
    axi_addr_t b;
    l = '0;
    for (int k = 0; k <= int'(blks) && k < LINE_BEATS; k++) begin
      for (int j = 0; j < 8; j++) begin
        b = {a[31:3], 3'b000} + axi_addr_t'(8 * k + j);
        l[64*k + 8*j +: 8] = model_byte(b);
      end
    end
    return l;
  endfunction

  function automatic void model_write(input axi_addr_t a, input req_size_t size,
                                      input req_blks_t blks, input line_t l);
    int nbytes;
    nbytes = (size == 2'd3) ? 8 * (int'(blks) + 1) : (1 << size);
    if (a < ERR_BASE) begin
      for (int i = 0; i < nbytes; i++) model_mem[a + axi_addr_t'(i)] = l[8*i +: 8];
    end
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < 16; i++) l[32*i +: 32] = $random(seed);
    return l;
  endfunction

  // Upper half is random to exercise the address truncation.
  function automatic req_addr_t random_line_addr(input axi_addr_t base);
    req_addr_t a;
    a[63:32] = $random(seed);
    a[31:0]  = base + axi_addr_t'(($random(seed) & (LINES - 1)) * 64);
    return a;
  endfunction

  function automatic req_addr_t random_narrow_addr(input axi_addr_t base, input int size);
    req_addr_t a;
    int        off;
    a   = random_line_addr(base);
    off = ($random(seed) & 63) & ~((1 << size) - 1);
    return a + req_addr_t'(off);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // One user request.
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic run_request(input string name, input req_op_e op, input req_addr_t addr,
                             input req_size_t size, input req_blks_t blks, input line_t wline);
    mem_req_t  req;
    line_t     rdata;
    axi_resp_t resp;
    axi_addr_t a;
    int        cycles;
    a          = addr[31:0];
    req.op     = op;
    req.addr   = addr;
    req.size   = size;
    req.blks   = blks;
    req.wline  = wline;
    cycles     = 0;
    @(posedge clock);
    user_req_i   <= req;
    user_valid_i <= 1'b1;
    @(negedge clock);
    while (!user_ready_o) begin
      if (cycles == TIMEOUT) abort_run({"Timeout waiting for user_ready_o in ", name});
      cycles++;
      @(negedge clock);
    end
    rdata = user_rdata_o;
    resp  = user_resp_o;
    @(posedge clock);
    user_valid_i <= 1'b0;
    compare_value({name, " resp"}, expected_resp(a), resp);
    compare_value({name, " id"}, AXI_ID, seen_ax.id);
    compare_value({name, " burst"}, AXI_BURST_INCR, seen_ax.burst);
    compare_value({name, " len"}, blks, seen_ax.len);
    compare_value({name, " size"}, size, seen_ax.size);
    compare_value({name, " addr"}, a, seen_ax.addr);
    compare_value({name, " protocol"}, 0, proto_err);
    if (op == REQ_READ) begin
      compare_value({name, " rdata"}, expected_read(a, blks), rdata);
    end else begin
      model_write(a, size, blks, wline);
    end
  endtask

  initial begin
    req_addr_t addr;
    axi_addr_t base;
    req_op_e   op;
    int        sz;
    reset_i      = 1'b1;
    user_valid_i = 1'b0;
    user_req_i   = '0;

    for (int i = 0; i < 16; i++) begin
      @(negedge clock);
      check_outputs_idle("in reset");
    end
    @(posedge clock);
    reset_i <= 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_outputs_idle("after reset");
    end

    // Full line round trip.
    addr = random_line_addr(NORM_BASE);
    run_request("full write", REQ_WRITE, addr, 2'd3, 8'd7, random_line());
    run_request("full read", REQ_READ, addr, 2'd3, 8'd7, '0);

    // Narrow writes then a full line read.
    for (int s = 0; s < 3; s++) begin
      repeat (4) begin
        addr = random_narrow_addr(NORM_BASE, s);
        run_request("narrow write", REQ_WRITE, addr, req_size_t'(s), 8'd0, random_line());
        run_request("narrow check", REQ_READ, {addr[63:6], 6'd0}, 2'd3, 8'd7, '0);
      end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Error range.
    // ~~~~~~~~~~~~~~~~~~~~
    addr = random_line_addr(ERR_BASE);
    run_request("error write", REQ_WRITE, addr, 2'd3, 8'd7, random_line());
    run_request("error read", REQ_READ, addr, 2'd3, 8'd7, '0);
    addr = random_narrow_addr(ERR_BASE, 1);
    run_request("error narrow write", REQ_WRITE, addr, 2'd1, 8'd0, random_line());
    run_request("error narrow read", REQ_READ, addr, 2'd1, 8'd0, '0);

    // Mixed traffic under random stalls.
    for (int i = 0; i < 200; i++) begin
      base = (($random(seed) & 7) == 0) ? ERR_BASE : NORM_BASE;
      sz   = $unsigned($random(seed)) % 4;
      op   = ($random(seed) & 1) ? REQ_WRITE : REQ_READ;
      if (sz == 3) begin
        addr = random_line_addr(base);
      end else begin
        addr = random_narrow_addr(base, sz);
      end
      run_request("mixed", op, addr, req_size_t'(sz), (sz == 3) ? 8'd7 : 8'd0, random_line());
    end

    $display("sim passed");
    $finish;
  end

endmodule

// File: tb_axi_slave_mem.sv
`timescale 1ns/1ps

module tb_axi_slave_mem
  import axi_pkg::*;
#(
  parameter axi_addr_t ERR_BASE = 32'h9000_0000
) (
  input  logic      clock,
  input  logic      reset_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_ax_t   aw_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  input  axi_w_t    w_i,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  output axi_resp_t b_resp_o,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  axi_ax_t   ar_i,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output axi_r_t    r_o,
  output axi_ax_t   seen_ax_o,
  output logic      proto_err_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WDATA,
    S_BRESP,
    S_RDATA
  } state_e;

  logic [7:0] mem [axi_addr_t];
  integer     seed = 23;
  state_e     state;
  axi_len_t   beat;
  logic       err;

  // Unwritten bytes read back as a pattern of their address.
  function automatic logic [7:0] fill_byte(input axi_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  function automatic axi_data_t read_word(input axi_addr_t a);
    axi_data_t w;
    axi_addr_t b;
    for (int j = 0; j < 8; j++) begin
      b = a + axi_addr_t'(j);
      w[8*j +: 8] = mem.exists(b) ? mem[b] : fill_byte(b);
    end
    return w;
  endfunction

  // Aligned bus word of beat k.
  function automatic axi_addr_t beat_addr(input axi_len_t k);
    return {seen_ax_o.addr[31:3], 3'b000} + axi_addr_t'({k, 3'b000});
  endfunction

  // About three cycles in four.
  function automatic logic random_ready();
    return ($random(seed) & 3) != 0;
  endfunction

  always @(posedge clock) begin
    if (reset_i) begin
      state       <= S_IDLE;
      aw_ready_o  <= 1'b0;
      w_ready_o   <= 1'b0;
      b_valid_o   <= 1'b0;
      b_resp_o    <= AXI_RESP_OKAY;
      ar_ready_o  <= 1'b0;
      r_valid_o   <= 1'b0;
      r_o         <= '0;
      seen_ax_o   <= '0;
      proto_err_o <= 1'b0;
      beat        <= '0;
      err         <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          aw_ready_o <= random_ready();
          ar_ready_o <= random_ready();
          // W ahead of its address phase.
          if (w_valid_i) proto_err_o <= 1'b1;
          if (aw_valid_i && aw_ready_o) begin
            seen_ax_o  <= aw_i;
            err        <= (aw_i.addr >= ERR_BASE);
            beat       <= '0;
            aw_ready_o <= 1'b0;
            ar_ready_o <= 1'b0;
            state      <= S_WDATA;
          end else if (ar_valid_i && ar_ready_o) begin
            seen_ax_o  <= ar_i;
            err        <= (ar_i.addr >= ERR_BASE);
            beat       <= '0;
            aw_ready_o <= 1'b0;
            ar_ready_o <= 1'b0;
            state      <= S_RDATA;
          end
        end
        S_WDATA: begin
          w_ready_o <= random_ready();
          if (w_valid_i && w_ready_o) begin
            if (w_i.last != (beat == seen_ax_o.len)) proto_err_o <= 1'b1;
            for (int j = 0; j < 8; j++) begin
              if (!err && w_i.strb[j]) mem[beat_addr(beat) + axi_addr_t'(j)] = w_i.data[8*j +: 8];
            end
            beat <= beat + 1'b1;
            if (w_i.last) begin
              w_ready_o <= 1'b0;
              b_resp_o  <= err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
              state     <= S_BRESP;
            end
          end
        end
        S_BRESP: begin
          if (w_valid_i) proto_err_o <= 1'b1;
          if (!b_valid_o) begin
            b_valid_o <= random_ready();
          end else if (b_ready_i) begin
            b_valid_o <= 1'b0;
            state     <= S_IDLE;
          end
        end
        S_RDATA: begin
          if (r_valid_o) begin
            if (r_ready_i) begin
              r_valid_o <= 1'b0;
              beat      <= beat + 1'b1;
              if (r_o.last) state <= S_IDLE;
            end
          end else if (random_ready()) begin
            r_valid_o <= 1'b1;
            r_o.data  <= read_word(beat_addr(beat));
            r_o.resp  <= err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            r_o.last  <= (beat == seen_ax_o.len);
            r_o.id    <= seen_ax_o.id;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule
